// File: project.f
+incdir+.
bus_pkg.sv
core_pkg.sv
fetch_unit.sv
lsu.sv
clint.sv
mem_interconnect.sv
mem_subsys.sv
tb_mem_subsys.sv

// File: run.sh
#!/bin/bash
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --top-module tb_mem_subsys -f project.f -o tb_mem_subsys \
    && ./obj_dir/tb_mem_subsys > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "^TEST PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_mem_subsys.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module tb_mem_subsys
    import bus_pkg::*;
    import core_pkg::*;
;

    // handshake bound per transfer and run budget in cycles
    localparam int WAIT_LIMIT      = 64;
    localparam int MTIP_LIMIT      = 2000;
    // worst case of all tests at three wait states plus the mtip wait and margin
    localparam int WATCHDOG_CYCLES = 20000;
    localparam addr_t MTIME_ADDR    = `CLINT_BASE | {16'h0000, `MTIME_OFS};
    localparam addr_t MTIMECMP_ADDR = `CLINT_BASE | {16'h0000, `MTIMECMP_OFS};

    logic      inst_selfdefine = 1'b0;
    logic      reset;
    logic      next;
    logic      redirect;
    addr_t     redirect_pc;
    logic      inst_valid;
    inst_t     inst;
    addr_t     inst_addr;
    logic      req;
    logic      write;
    lsu_size_t size;
    logic      unsigned_load;
    addr_t     addr;
    data_t     wdata;
    logic      busy;
    logic      done;
    data_t     rdata;
    logic      m_cyc;
    logic      m_stb;
    logic      m_we;
    addr_t     m_adr;
    data_t     m_dat_w;
    sel_t      m_sel;
    data_t     m_dat_r = '0;
    logic      m_ack = 1'b0;
    logic      mtip;

    data_t       mem [0:1023];
    data_t       ref_mem [0:1023];
    int          errors = 0;
    int          checks = 0;
    int          lsu_ops = 0;
    int          done_count = 0;
    addr_t       fetch_pc;
    logic [31:0] model_lcg = 32'd33;
    int          wait_left = 0;

    mem_subsys mem_subsys_i (.*);

    always #20 inst_selfdefine = ~inst_selfdefine;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory pattern with each 32-bit half tied to its own address
    function automatic data_t fill_word(input addr_t a);
        return {(a + 32'd4) ^ 32'h5a5a_0000, a ^ 32'ha5a5_0000};
    endfunction

    function automatic inst_t expected_inst(input addr_t a);
        return a[2] ? (a ^ 32'h5a5a_0000) : (a ^ 32'ha5a5_0000);
    endfunction

    function automatic data_t expected_load(input lsu_size_t sz, input logic uns, input addr_t a);
        data_t word;
        data_t res;
        int    off;
        int    nbytes;
        word   = ref_mem[a[12:3]];
        off    = int'(a[2:0]);
        nbytes = 1 << int'(sz);
        res    = '0;
        for (int k = 0; k < 8; k++) begin
            if (k < nbytes) begin
                res[k*8 +: 8] = word[(off + k) * 8 +: 8];
            end else if (!uns && res[nbytes * 8 - 1]) begin
                res[k*8 +: 8] = 8'hff;
            end
        end
        return res;
    endfunction

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic wait_cycle();
        @(posedge inst_selfdefine);
        #2;
    endtask

    // external memory with random wait states
    always @(posedge inst_selfdefine) begin
        #2;
        if (reset) begin
            m_ack = 1'b0;
        end else if (m_ack) begin
            m_ack = 1'b0;
            model_lcg = lcg(model_lcg);
            wait_left = int'(model_lcg[31:30]);
        end else if (m_cyc && m_stb) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                if ((m_adr & `CLINT_MASK) == `CLINT_BASE) begin
                    errors++;
                    $display("a CLINT access at %h reached the external bus", m_adr);
                end
                if (m_adr[31:13] != 19'h4_0000) begin
                    errors++;
                    $display("external access at %h lies outside the memory model", m_adr);
                end
                if (m_we) begin
                    for (int k = 0; k < 8; k++) begin
                        if (m_sel[k]) begin
                            mem[m_adr[12:3]][k*8 +: 8] = m_dat_w[k*8 +: 8];
                        end
                    end
                end
                m_dat_r = mem[m_adr[12:3]];
                m_ack = 1'b1;
            end
        end
    end

    always @(posedge inst_selfdefine) begin
        if (!reset && done) begin
            done_count++;
        end
    end

    task automatic wait_for_inst(input string name);
        int n;
        n = 0;
        while (!inst_valid && n < WAIT_LIMIT) begin
            wait_cycle();
            n++;
        end
        if (!inst_valid) begin
            errors++;
            $display("%s: no instruction arrived within %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    task automatic consume_inst(input string name);
        wait_for_inst(name);
        check_addr({name, " address"}, fetch_pc, inst_addr);
        check_inst(name, expected_inst(fetch_pc), inst);
        next = 1'b1;
        wait_cycle();
        next = 1'b0;
        fetch_pc = fetch_pc + 32'd4;
    endtask

    task automatic redirect_to(input string name, input addr_t target);
        wait_for_inst(name);
        redirect    = 1'b1;
        redirect_pc = target;
        wait_cycle();
        redirect = 1'b0;
        fetch_pc = target;
    endtask

    task automatic lsu_access(input logic wr, input lsu_size_t sz, input logic uns,
                              input addr_t a, input data_t wd, output data_t rd);
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            wait_cycle();
            n++;
        end
        req           = 1'b1;
        write         = wr;
        size          = sz;
        unsigned_load = uns;
        addr          = a;
        wdata         = wd;
        wait_cycle();
        req = 1'b0;
        check_flag("lsu busy", 1'b1, busy);
        n = 0;
        do begin
            wait_cycle();
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) begin
            errors++;
            $display("lsu transfer at %h did not complete within %0d cycles", a, WAIT_LIMIT);
        end
        check_flag("lsu idle at done", 1'b0, busy);
        rd = rdata;
        lsu_ops++;
    endtask

    task automatic store_and_check(input string name, input lsu_size_t sz, input addr_t a,
                                   input data_t wd);
        data_t      rd;
        logic [9:0] idx;
        int         off;
        int         nbytes;
        idx    = a[12:3];
        off    = int'(a[2:0]);
        nbytes = 1 << int'(sz);
        for (int k = 0; k < 8; k++) begin
            if (k < nbytes) begin
                ref_mem[idx][(off + k) * 8 +: 8] = wd[k*8 +: 8];
            end
        end
        lsu_access(1'b1, sz, 1'b0, a, wd, rd);
        check_data(name, '0, rd);
        check_data({name, " memory word"}, ref_mem[idx], mem[idx]);
    endtask

    task automatic load_and_check(input string name, input lsu_size_t sz, input logic uns,
                                  input addr_t a);
        data_t rd;
        data_t exp;
        exp = expected_load(sz, uns, a);
        lsu_access(1'b0, sz, uns, a, '0, rd);
        check_data(name, exp, rd);
    endtask

    task automatic fetch_sequence();
        fetch_pc = `PC_START;
        for (int i = 0; i < 8; i++) begin
            consume_inst($sformatf("fetch sequence %0d", i));
        end
    endtask

    task automatic fetch_redirect();
        redirect_to("redirect upper half", 32'h8000_0124);
        for (int i = 0; i < 5; i++) begin
            consume_inst($sformatf("after redirect a %0d", i));
        end
        redirect_to("redirect lower half", 32'h8000_0040);
        for (int i = 0; i < 5; i++) begin
            consume_inst($sformatf("after redirect b %0d", i));
        end
    endtask

    task automatic store_load_sizes();
        addr_t base;
        base = 32'h8000_1000;
        store_and_check("store dword", size_dword, base, 64'h8123_4567_89ab_cdef);
        store_and_check("store word low", size_word, base + 32'h08, 64'h1111_2222_f00d_cafe);
        store_and_check("store word high", size_word, base + 32'h0c, 64'h7654_3210);
        store_and_check("store half 0", size_half, base + 32'h10, 64'h8001);
        store_and_check("store half 2", size_half, base + 32'h12, 64'hffff_7ffe);
        store_and_check("store half 6", size_half, base + 32'h16, 64'hbeef);
        store_and_check("store byte 0", size_byte, base + 32'h18, 64'h80);
        store_and_check("store byte 3", size_byte, base + 32'h1b, 64'h7f);
        store_and_check("store byte 7", size_byte, base + 32'h1f, 64'haa_c3);
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 32; o += (1 << s)) begin
                for (int u = 0; u < 2; u++) begin
                    load_and_check($sformatf("load size %0d at %h unsigned %0d", s,
                                             base + 32'(o), u),
                                   lsu_size_t'(s), u[0], base + 32'(o));
                end
            end
        end
    endtask

    task automatic timer_interrupt();
        data_t t1;
        data_t t2;
        data_t cmp;
        data_t rd;
        int    n;
        check_flag("mtip after reset", 1'b0, mtip);
        lsu_access(1'b0, size_dword, 1'b0, MTIME_ADDR, '0, t1);
        lsu_access(1'b0, size_dword, 1'b0, MTIME_ADDR, '0, t2);
        check_flag("mtime increases", 1'b1, t2 > t1);
        lsu_access(1'b1, size_dword, 1'b0, MTIMECMP_ADDR, '0, rd);
        repeat (3) wait_cycle();
        check_flag("mtip with mtimecmp zero", 1'b1, mtip);
        // compare point a few hundred cycles ahead
        lsu_access(1'b0, size_dword, 1'b0, MTIME_ADDR, '0, t1);
        cmp = t1 + 64'd400;
        lsu_access(1'b1, size_dword, 1'b0, MTIMECMP_ADDR, cmp, rd);
        lsu_access(1'b0, size_dword, 1'b0, MTIMECMP_ADDR, '0, rd);
        check_data("mtimecmp readback", cmp, rd);
        repeat (2) wait_cycle();
        check_flag("mtip cleared", 1'b0, mtip);
        n = 0;
        while (!mtip && n < MTIP_LIMIT) begin
            wait_cycle();
            n++;
        end
        if (!mtip) begin
            errors++;
            $display("mtip did not rise within %0d cycles", MTIP_LIMIT);
        end
        lsu_access(1'b0, size_dword, 1'b0, MTIME_ADDR, '0, t2);
        check_flag("mtime past mtimecmp", 1'b1, t2 >= cmp);
    endtask

    task automatic mixed_traffic();
        logic [31:0] st;
        logic [31:0] st2;
        logic        wr;
        logic        uns;
        lsu_size_t   sz;
        logic [2:0]  off3;
        addr_t       a;
        data_t       wd;
        st = 32'd33;
        redirect_to("mixed redirect", 32'h8000_0200);
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    consume_inst($sformatf("mixed fetch %0d", i));
                end
            end
            begin
                for (int i = 0; i < 40; i++) begin
                    st   = lcg(st);
                    wr   = st[31];
                    uns  = st[28];
                    sz   = lsu_size_t'(st[30:29]);
                    off3 = st[22:20] & ~((3'd1 << st[30:29]) - 3'd1);
                    a    = {24'h80_0018, st[27:23], off3};
                    st2  = lcg(st);
                    st   = lcg(st2);
                    wd   = {st2, st};
                    if (wr) begin
                        store_and_check($sformatf("mixed store %0d", i), sz, a, wd);
                    end else begin
                        load_and_check($sformatf("mixed load %0d", i), sz, uns, a);
                    end
                end
            end
        join
        wait_cycle();
        check_data("lsu done count", data_t'(lsu_ops), data_t'(done_count));
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i]     = fill_word(32'h8000_0000 + 32'(i * 8));
            ref_mem[i] = mem[i];
        end
        reset         = 1'b1;
        next          = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        req           = 1'b0;
        write         = 1'b0;
        size          = size_byte;
        unsigned_load = 1'b0;
        addr          = '0;
        wdata         = '0;
        repeat (16) @(posedge inst_selfdefine);
        #2;
        reset = 1'b0;
        fetch_sequence();
        fetch_redirect();
        store_load_sizes();
        timer_interrupt();
        mixed_traffic();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge inst_selfdefine);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: mem_subsys.sv
`timescale 1ns/100ps

module mem_subsys
    import bus_pkg::*;
    import core_pkg::*;
(
    input  logic      inst_selfdefine,
    input  logic      reset,
    input  logic      next,
    input  logic      redirect,
    input  addr_t     redirect_pc,
    output logic      inst_valid,
    output inst_t     inst,
    output addr_t     inst_addr,
    input  logic      req,
    input  logic      write,
    input  lsu_size_t size,
    input  logic      unsigned_load,
    input  addr_t     addr,
    input  data_t     wdata,
    output logic      busy,
    output logic      done,
    output data_t     rdata,
    output logic      m_cyc,
    output logic      m_stb,
    output logic      m_we,
    output addr_t     m_adr,
    output data_t     m_dat_w,
    output sel_t      m_sel,
    input  data_t     m_dat_r,
    input  logic      m_ack,
    output logic      mtip
);

    // fetch bus
    logic  f_cyc;
    logic  f_stb;
    addr_t f_adr;
    data_t f_dat_r;
    logic  f_ack;

    // load/store bus
    logic  d_cyc;
    logic  d_stb;
    logic  d_we;
    addr_t d_adr;
    data_t d_dat_w;
    sel_t  d_sel;
    data_t d_dat_r;
    logic  d_ack;

    // timer bus
    logic  c_cyc;
    logic  c_stb;
    logic  c_we;
    addr_t c_adr;
    data_t c_dat_w;
    sel_t  c_sel;
    data_t c_dat_r;
    logic  c_ack;

    fetch_unit fetch_unit_i (.*);

    lsu lsu_i (.*);

    clint clint_i (.*);

    mem_interconnect mem_interconnect_i (.*);

endmodule

// File: mem_interconnect.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_interconnect
    import bus_pkg::*;
(
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  f_cyc,
    input  logic  f_stb,
    input  addr_t f_adr,
    output data_t f_dat_r,
    output logic  f_ack,
    input  logic  d_cyc,
    input  logic  d_stb,
    input  logic  d_we,
    input  addr_t d_adr,
    input  data_t d_dat_w,
    input  sel_t  d_sel,
    output data_t d_dat_r,
    output logic  d_ack,
    output logic  c_cyc,
    output logic  c_stb,
    output logic  c_we,
    output addr_t c_adr,
    output data_t c_dat_w,
    output sel_t  c_sel,
    input  data_t c_dat_r,
    input  logic  c_ack,
    output logic  m_cyc,
    output logic  m_stb,
    output logic  m_we,
    output addr_t m_adr,
    output data_t m_dat_w,
    output sel_t  m_sel,
    input  data_t m_dat_r,
    input  logic  m_ack
);

    logic gnt_f;
    logic gnt_d;
    logic route_c;
    logic idle;
    logic d_is_clint;
    logic own_d;
    logic own_f;
    logic use_clint;
    logic d_to_m;

    assign idle       = !gnt_f && !gnt_d;
    assign d_is_clint = (d_adr & `CLINT_MASK) == `CLINT_BASE;

    // owner this cycle, data master first when idle
    assign own_d     = gnt_d || (idle && d_cyc);
    assign own_f     = gnt_f || (idle && f_cyc && !d_cyc);
    assign use_clint = gnt_d ? route_c : d_is_clint;
    assign d_to_m    = own_d && !use_clint;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            gnt_f   <= 1'b0;
            gnt_d   <= 1'b0;
            route_c <= 1'b0;
        end else begin
            gnt_d <= own_d && !d_ack;
            gnt_f <= own_f && !f_ack;
            if (idle) begin
                route_c <= d_is_clint;
            end
        end
    end

    assign c_cyc   = own_d && use_clint && d_cyc;
    assign c_stb   = own_d && use_clint && d_stb;
    assign c_we    = d_we;
    assign c_adr   = d_adr;
    assign c_dat_w = d_dat_w;
    assign c_sel   = d_sel;

    assign m_cyc   = (d_to_m && d_cyc) || (own_f && f_cyc);
    assign m_stb   = (d_to_m && d_stb) || (own_f && f_stb);
    assign m_we    = d_to_m && d_we;
    assign m_adr   = own_d ? d_adr : f_adr;
    assign m_dat_w = d_to_m ? d_dat_w : '0;
    assign m_sel   = own_d ? d_sel : 8'hff;

    // responses go back to the owner only
    assign d_ack   = own_d && (use_clint ? c_ack : m_ack);
    assign d_dat_r = own_d ? (use_clint ? c_dat_r : m_dat_r) : '0;
    assign f_ack   = own_f && m_ack;
    assign f_dat_r = own_f ? m_dat_r : '0;

endmodule

// File: clint.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module clint
    import bus_pkg::*;
(
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  c_cyc,
    input  logic  c_stb,
    input  logic  c_we,
    input  addr_t c_adr,
    input  data_t c_dat_w,
    input  sel_t  c_sel,
    output data_t c_dat_r,
    output logic  c_ack,
    output logic  mtip
);

    data_t       mtime;
    data_t       mtimecmp;
    logic [15:0] ofs;
    logic        access;
    logic        wr_time;
    logic        wr_cmp;

    function automatic data_t merge_lanes(data_t old_val, data_t new_val, sel_t sel);
        data_t res;
        res = old_val;
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // one access per request, ack keeps it from repeating
    assign ofs     = c_adr[15:0];
    assign access  = c_cyc && c_stb && !c_ack;
    assign wr_time = access && c_we && (ofs == `MTIME_OFS);
    assign wr_cmp  = access && c_we && (ofs == `MTIMECMP_OFS);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '1;
            c_ack    <= 1'b0;
            mtip     <= 1'b0;
        end else begin
            c_ack <= access;
            if (wr_time) begin
                mtime <= merge_lanes(mtime, c_dat_w, c_sel);
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (wr_cmp) begin
                mtimecmp <= merge_lanes(mtimecmp, c_dat_w, c_sel);
            end
            mtip <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (access) begin
            case (ofs)
                `MTIME_OFS:    c_dat_r <= mtime;
                `MTIMECMP_OFS: c_dat_r <= mtimecmp;
                default:       c_dat_r <= '0;
            endcase
        end
    end

endmodule

// File: lsu.sv
`timescale 1ns/100ps

module lsu
    import bus_pkg::*;
    import core_pkg::*;
(
    input  logic      inst_selfdefine,
    input  logic      reset,
    input  logic      req,
    input  logic      write,
    input  lsu_size_t size,
    input  logic      unsigned_load,
    input  addr_t     addr,
    input  data_t     wdata,
    output logic      busy,
    output logic      done,
    output data_t     rdata,
    output logic      d_cyc,
    output logic      d_stb,
    output logic      d_we,
    output addr_t     d_adr,
    output data_t     d_dat_w,
    output sel_t      d_sel,
    input  data_t     d_dat_r,
    input  logic      d_ack
);

    logic       cyc_r;
    logic       write_r;
    lsu_size_t  size_r;
    logic       unsigned_r;
    addr_t      addr_r;
    data_t      wdata_r;
    logic [5:0] shamt;
    logic       sext;
    data_t      lanes;
    data_t      load_data;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            cyc_r <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!cyc_r) begin
                if (req) begin
                    cyc_r <= 1'b1;
                end
            end else if (d_ack) begin
                cyc_r <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (!cyc_r && req) begin
            write_r    <= write;
            size_r     <= size;
            unsigned_r <= unsigned_load;
            addr_r     <= addr;
            wdata_r    <= wdata;
        end
        // stores hand back zero
        if (cyc_r && d_ack) begin
            rdata <= write_r ? '0 : load_data;
        end
    end

    // byte offset inside the double word, in bits
    assign shamt = {addr_r[2:0], 3'b000};

    always_comb begin
        case (size_r)
            size_byte: d_sel = 8'h01 << addr_r[2:0];
            size_half: d_sel = 8'h03 << addr_r[2:0];
            size_word: d_sel = 8'h0f << addr_r[2:0];
            default:   d_sel = 8'hff;
        endcase
    end

    assign lanes = d_dat_r >> shamt;
    assign sext  = !unsigned_r;

    always_comb begin
        case (size_r)
            size_byte: load_data = {{56{sext & lanes[7]}}, lanes[7:0]};
            size_half: load_data = {{48{sext & lanes[15]}}, lanes[15:0]};
            size_word: load_data = {{32{sext & lanes[31]}}, lanes[31:0]};
            default:   load_data = lanes;
        endcase
    end

    assign busy    = cyc_r;
    assign d_cyc   = cyc_r;
    assign d_stb   = cyc_r;
    assign d_we    = write_r;
    assign d_adr   = {addr_r[31:3], 3'b000};
    assign d_dat_w = wdata_r << shamt;

endmodule

// File: fetch_unit.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module fetch_unit
    import bus_pkg::*;
    import core_pkg::*;
(
    input  logic  inst_selfdefine,
    input  logic  reset,
    input  logic  next,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output logic  inst_valid,
    output inst_t inst,
    output addr_t inst_addr,
    output logic  f_cyc,
    output logic  f_stb,
    output addr_t f_adr,
    input  data_t f_dat_r,
    input  logic  f_ack
);

    addr_t pc;
    logic  cyc_r;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pc         <= `PC_START;
            cyc_r      <= 1'b0;
            inst_valid <= 1'b0;
        end else if (cyc_r) begin
            if (f_ack) begin
                cyc_r      <= 1'b0;
                inst_valid <= 1'b1;
            end
        end else if (inst_valid) begin
            // instruction held until the core takes it
            if (redirect) begin
                pc         <= redirect_pc;
                inst_valid <= 1'b0;
                cyc_r      <= 1'b1;
            end else if (next) begin
                pc         <= pc + 32'd4;
                inst_valid <= 1'b0;
                cyc_r      <= 1'b1;
            end
        end else begin
            // first fetch out of reset
            cyc_r <= 1'b1;
        end
    end

    // pick the half of the double word by pc bit 2
    always_ff @(posedge inst_selfdefine) begin
        if (cyc_r && f_ack) begin
            inst <= pc[2] ? f_dat_r[63:32] : f_dat_r[31:0];
        end
    end

    assign inst_addr = pc;
    assign f_cyc     = cyc_r;
    assign f_stb     = cyc_r;
    assign f_adr     = {pc[31:3], 3'b000};

endmodule

// File: core_pkg.sv
package core_pkg;

    localparam int INST_W = 32;

    // one instruction as fetched
    typedef logic [INST_W-1:0] inst_t;

    // load and store access sizes
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } lsu_size_t;

endpackage

// File: bus_pkg.sv
package bus_pkg;

    // widths of the Wishbone buses
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int SEL_W  = DATA_W / 8;

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // one double word of data
    typedef logic [DATA_W-1:0] data_t;

    // one bit per byte lane
    typedef logic [SEL_W-1:0]  sel_t;

endpackage

// File: mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// program counter after reset
`define PC_START        32'h8000_0000

// 64 KiB machine timer window
`define CLINT_BASE      32'h0200_0000
`define CLINT_MASK      32'hffff_0000

// register offsets inside the timer window
`define MTIMECMP_OFS    16'h4000
`define MTIME_OFS       16'hbff8

`endif
